//--- all.f
logic/spi_pkg.sv
logic/spi_credit_fifo.sv
logic/spi_shift_engine.sv
logic/spi_master_driver.sv
logic/spi_master_top.sv
test/spi_slave_model.sv
test/spi_tb.sv

//--- logic/spi_credit_fifo.sv
`timescale 1ns/1ps

module spi_credit_fifo #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4  // power of two, pointers wrap on overflow
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t pop_data,
  output logic     empty,
  output logic     full,
  output logic     credit
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);
  localparam logic [CNT_W-1:0] CNT_FULL = CNT_W'(DEPTH);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;  // entries held

  assign pop_data = mem[rd_ptr];  // head is always visible
  assign empty    = (count == '0);
  assign full     = (count == CNT_FULL);

  // storage, no reset needed
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= wr_ptr + 1'b1;
      if (pop) rd_ptr <= rd_ptr + 1'b1;
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;  // both or neither
      endcase
      credit <= pop;  // one credit back per freed slot
    end
  end

  //////////////////////////////
  // protocol checks
  //////////////////////////////

  // sender ran past its credits
  a_no_overflow : assert property (@(posedge clk) disable iff (rst) !(push && full))
    else $error("spi_credit_fifo: push while full");

  // consumer popped without looking at empty
  a_no_underflow : assert property (@(posedge clk) disable iff (rst) !(pop && empty))
    else $error("spi_credit_fifo: pop while empty");

endmodule

//--- logic/spi_master_driver.sv
`timescale 1ns/1ps

module spi_master_driver (
  input  logic              clk,
  input  logic              rst,
  input  logic              start,
  input  spi_pkg::spi_cmd_t tx,
  output logic              busy,
  output logic              done,
  output spi_pkg::spi_rsp_t rx,
  output logic              sclk,
  output logic              cs,
  output logic              mosi,
  input  logic              miso
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT_HIGH,  // sclk low, waiting to raise it
    ST_WAIT_LOW,   // sclk high, waiting to drop it
    ST_FINALIZE    // last half period before cs rises
  } state_t;

  state_t                           state;
  logic [spi_pkg::BIT_CNT_W-1:0]    bit_cnt;   // bits left after this one
  logic [spi_pkg::HALF_CNT_W-1:0]   half_cnt;
  logic                             half_end;
  logic                             cs_rise;   // cs went high this cycle
  logic [spi_pkg::DATA_WIDTH-1:0]   word;

  assign half_end = (half_cnt == '0);
  assign rx.data  = word;

  // hold off until the response is pushed, so the top sees a true full flag
  assign busy = (state != ST_IDLE) | cs_rise | done;

  //////////////////////////////
  // transaction fsm
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state    <= ST_IDLE;
      bit_cnt  <= '0;
      half_cnt <= '0;
      sclk     <= 1'b0;
      cs       <= 1'b1;
      cs_rise  <= 1'b0;
      done     <= 1'b0;
    end else begin
      cs_rise <= 1'b0;
      done    <= cs_rise;  // response word settled by now
      if (state != ST_IDLE) begin
        half_cnt <= half_end ? spi_pkg::HALF_RELOAD : half_cnt - 1'b1;
      end
      case (state)
        ST_IDLE: begin
          sclk <= 1'b0;
          if (start) begin
            bit_cnt  <= spi_pkg::LAST_BIT;
            half_cnt <= spi_pkg::HALF_RELOAD;
            cs       <= 1'b0;
            state    <= ST_WAIT_HIGH;
          end
        end
        ST_WAIT_HIGH: begin
          if (half_end) begin
            sclk  <= 1'b1;
            state <= ST_WAIT_LOW;
          end
        end
        ST_WAIT_LOW: begin
          if (half_end) begin
            sclk <= 1'b0;
            if (bit_cnt == '0) begin
              state <= ST_FINALIZE;
            end else begin
              bit_cnt <= bit_cnt - 1'b1;
              state   <= ST_WAIT_HIGH;
            end
          end
        end
        ST_FINALIZE: begin
          if (half_end) begin
            cs      <= 1'b1;
            cs_rise <= 1'b1;
            state   <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  spi_shift_engine spi_shift_engine_i (
    .clk       (clk),
    .rst       (rst),
    .load      (start),
    .load_data (tx.data),
    .sclk      (sclk),
    .cs        (cs),
    .sout      (mosi),
    .sin       (miso),
    .word      (word)
  );

  // cpol=0 idle level outside a frame
  a_sclk_idle : assert property (@(posedge clk) disable iff (rst) cs |-> !sclk)
    else $error("spi_master_driver: sclk high while cs high");

endmodule

//--- logic/spi_master_top.sv
`timescale 1ns/1ps

module spi_master_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              cmd_valid,
  input  spi_pkg::spi_cmd_t cmd,
  output logic              cmd_credit,
  output logic              rsp_valid,
  output spi_pkg::spi_rsp_t rsp,
  input  logic              rsp_credit,
  output logic              sclk,
  output logic              cs,
  output logic              mosi,
  input  logic              miso
);

  spi_pkg::spi_cmd_t               cmd_head;
  spi_pkg::spi_rsp_t               rx_word;
  logic                            cmd_empty;
  logic                            rsp_empty;
  logic                            rsp_full;
  logic                            busy;
  logic                            done;
  logic                            take;
  logic [spi_pkg::RSP_CRED_W-1:0]  rsp_cred;  // credits the host has granted

  // start only if the answer has somewhere to go
  assign take      = ~busy & ~cmd_empty & ~rsp_full;
  assign rsp_valid = ~rsp_empty & (rsp_cred != '0);

  //////////////////////////////
  // response credit counter
  //////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      rsp_cred <= spi_pkg::RSP_CRED_INIT;
    end else begin
      case ({rsp_valid, rsp_credit})
        2'b10:   rsp_cred <= rsp_cred - 1'b1;
        2'b01:   rsp_cred <= rsp_cred + 1'b1;
        default: rsp_cred <= rsp_cred;  // spend and return cancel
      endcase
    end
  end

  spi_credit_fifo #(
    .payload_t (spi_pkg::spi_cmd_t),
    .DEPTH     (spi_pkg::CMD_DEPTH)
  ) cmd_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (cmd_valid),
    .push_data (cmd),
    .pop       (take),
    .pop_data  (cmd_head),
    .empty     (cmd_empty),
    .full      (),  // host credits keep it from filling past depth
    .credit    (cmd_credit)
  );

  spi_master_driver spi_master_driver_i (
    .clk   (clk),
    .rst   (rst),
    .start (take),
    .tx    (cmd_head),
    .busy  (busy),
    .done  (done),
    .rx    (rx_word),
    .sclk  (sclk),
    .cs    (cs),
    .mosi  (mosi),
    .miso  (miso)
  );

  spi_credit_fifo #(
    .payload_t (spi_pkg::spi_rsp_t),
    .DEPTH     (spi_pkg::RSP_DEPTH)
  ) rsp_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .push      (done),
    .push_data (rx_word),
    .pop       (rsp_valid),
    .pop_data  (rsp),
    .empty     (rsp_empty),
    .full      (rsp_full),
    .credit    ()  // space is tracked through full here
  );

endmodule

//--- logic/spi_pkg.sv
package spi_pkg;

  //////////////////////////////
  // word and queue sizing
  //////////////////////////////

  localparam int DATA_WIDTH = 32;  // bits per spi word
  localparam int CMD_DEPTH  = 4;   // also the host's starting command credits
  localparam int RSP_DEPTH  = 4;   // also the starting response credits

  // clk cycles per half period of sclk
  localparam int SCLK_HALF = 2;

  //////////////////////////////
  // derived counter widths
  //////////////////////////////

  localparam int BIT_CNT_W  = $clog2(DATA_WIDTH);
  localparam int HALF_CNT_W = $clog2(SCLK_HALF + 1);
  localparam int RSP_CRED_W = $clog2(RSP_DEPTH + 1);

  // reload values, sized to their counters
  localparam logic [BIT_CNT_W-1:0]  LAST_BIT    = BIT_CNT_W'(DATA_WIDTH - 1);
  localparam logic [HALF_CNT_W-1:0] HALF_RELOAD = HALF_CNT_W'(SCLK_HALF - 1);
  localparam logic [RSP_CRED_W-1:0] RSP_CRED_INIT = RSP_CRED_W'(RSP_DEPTH);

  //////////////////////////////
  // host payloads
  //////////////////////////////

  // word to shift out on mosi
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } spi_cmd_t;

  // word captured from miso
  typedef struct packed {
    logic [DATA_WIDTH-1:0] data;
  } spi_rsp_t;

endpackage

//--- logic/spi_shift_engine.sv
`timescale 1ns/1ps

module spi_shift_engine (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          load,
  input  logic [spi_pkg::DATA_WIDTH-1:0] load_data,
  input  logic                          sclk,
  input  logic                          cs,
  output logic                          sout,
  input  logic                          sin,
  output logic [spi_pkg::DATA_WIDTH-1:0] word
);

  logic                          sclk_q;  // last cycle's sclk
  logic                          sclk_rise;
  logic                          sclk_fall;
  logic [spi_pkg::DATA_WIDTH-1:0] tx_sr;
  logic [spi_pkg::DATA_WIDTH-1:0] rx_sr;

  assign sclk_rise = sclk & ~sclk_q & ~cs;
  assign sclk_fall = ~sclk & sclk_q & ~cs;
  assign word      = rx_sr;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      sclk_q <= 1'b0;
      sout   <= 1'b0;
    end else begin
      sclk_q <= sclk;
      if (sclk_rise) sout <= tx_sr[spi_pkg::DATA_WIDTH-1];  // cpha=1 launch
    end
  end

  // payload shifters
  always_ff @(posedge clk) begin
    if (load) begin
      tx_sr <= load_data;
    end else if (sclk_rise) begin
      tx_sr <= {tx_sr[spi_pkg::DATA_WIDTH-2:0], 1'b0};  // msb first
    end
    if (sclk_fall) begin
      rx_sr <= {rx_sr[spi_pkg::DATA_WIDTH-2:0], sin};  // sample on trailing edge
    end
  end

  // a new word must not land in the middle of a frame
  a_load_idle : assert property (@(posedge clk) disable iff (rst) load |-> cs)
    else $error("spi_shift_engine: load while cs low");

endmodule

//--- run.sh
#!/bin/sh
# build the spi master testbench with verilator, run it, scan the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module spi_tb -o spi_sim -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
  echo "verilator build failed with status $build_status"
  exit 1
fi

./obj_dir/spi_sim > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -qx "NO ERRORS" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed"
exit 1

//--- test/spi_slave_model.sv
`timescale 1ns/1ps

module spi_slave_model (
  input  logic                           sclk,
  input  logic                           cs,
  input  logic                           mosi,
  output logic                           miso,
  input  logic [spi_pkg::DATA_WIDTH-1:0] next_word,  // sent in the coming frame
  output logic [spi_pkg::DATA_WIDTH-1:0] frame_tx,   // word sent in the last frame
  output logic [spi_pkg::DATA_WIDTH-1:0] frame_rx,   // word taken from mosi
  output int                             frame_edges,
  output int                             frame_cnt
);

  logic [spi_pkg::DATA_WIDTH-1:0] tx_sr;
  logic [spi_pkg::DATA_WIDTH-1:0] rx_sr;
  int                             edges;  // rising sclk in this frame

  initial begin
    miso        = 1'b0;
    frame_tx    = '0;
    frame_rx    = '0;
    frame_edges = 0;
    frame_cnt   = 0;
    tx_sr       = '0;
    rx_sr       = '0;
    edges       = 0;
    forever begin
      @(negedge cs);
      tx_sr    = next_word;
      frame_tx = next_word;
      edges    = 0;
      while (cs == 1'b0) begin
        @(posedge sclk or negedge sclk or posedge cs);
        if (cs !== 1'b0) begin
          // frame closed, loop exits
        end else if (sclk) begin
          miso  = tx_sr[spi_pkg::DATA_WIDTH-1];  // cpha=1, launch on leading edge
          tx_sr = {tx_sr[spi_pkg::DATA_WIDTH-2:0], 1'b0};
          edges++;
        end else begin
          rx_sr = {rx_sr[spi_pkg::DATA_WIDTH-2:0], mosi};  // trailing edge sample
        end
      end
      frame_rx    = rx_sr;
      frame_edges = edges;
      frame_cnt++;
    end
  end

endmodule

//--- test/spi_tb.sv
`timescale 1ns/1ps

module spi_tb;

  localparam int NUM_WORDS  = 40;
  localparam int TIMEOUT    = NUM_WORDS * 200;  // cycles
  localparam int WINDOW_AT  = 10;               // responses before credits are held back
  localparam int WINDOW_LEN = 1500;             // cycles with no rsp_credit

  logic                           clk;
  logic                           rst;
  logic                           cmd_valid;
  spi_pkg::spi_cmd_t              cmd;
  logic                           cmd_credit;
  logic                           rsp_valid;
  spi_pkg::spi_rsp_t              rsp;
  logic                           rsp_credit;
  logic                           sclk;
  logic                           cs;
  logic                           mosi;
  logic                           miso;
  logic [spi_pkg::DATA_WIDTH-1:0] next_word;
  logic [spi_pkg::DATA_WIDTH-1:0] frame_tx;
  logic [spi_pkg::DATA_WIDTH-1:0] frame_rx;
  int                             frame_edges;
  int                             frame_cnt;

  logic [31:0]                    lfsr;
  logic [spi_pkg::DATA_WIDTH-1:0] cmd_q[$];   // commands not yet seen on mosi
  logic [spi_pkg::DATA_WIDTH-1:0] miso_q[$];  // slave words not yet seen on rsp
  int value_errors, other_errors;
  int cycle, frames_seen, sent, rsp_count;
  int cmd_cred = spi_pkg::CMD_DEPTH;   // host side command credits
  int cmd_returned;                    // cmd_credit pulses
  int rsp_avail = spi_pkg::RSP_DEPTH;  // credits the top should hold
  int owed, credit_wait, gap;
  int window_left, window_frames;
  bit withhold, window_done;

  always #5 clk = ~clk;

  spi_master_top spi_master_top_i (.*);
  spi_slave_model spi_slave_model_i (.*);

  //////////////////////////////
  // random source and checks
  //////////////////////////////

  // fibonacci taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("error at %0t: %s is %h, expected %h", $time, name, actual, expected);
      value_errors++;
    end
  endtask

  task automatic report_failure(input string what);
    $display("failure at %0t: %s", $time, what);
    other_errors++;
  endtask

  //////////////////////////////
  // stimulus and scoreboard
  //////////////////////////////

  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    rsp_credit = 1'b0;
    lfsr       = 32'h5c5cd50b;
    next_word  = random_bits(spi_pkg::DATA_WIDTH);
    repeat (10) @(negedge clk);
    check_value("cs", 32'(cs), 32'd1);
    check_value("sclk", 32'(sclk), 32'd0);
    check_value("rsp_valid", 32'(rsp_valid), 32'd0);
    check_value("cmd_credit", 32'(cmd_credit), 32'd0);
    rst = 1'b0;

    while (rsp_count < NUM_WORDS && cycle < TIMEOUT) begin
      @(negedge clk);
      cycle++;
      if (frame_cnt != frames_seen) begin  // slave just closed a frame
        frames_seen++;
        if (cmd_q.size() == 0) begin
          report_failure("slave saw a frame with no command pending");
        end else begin
          check_value("mosi word", frame_rx, cmd_q.pop_front());
        end
        check_value("sclk rises per frame", frame_edges, 32'(spi_pkg::DATA_WIDTH));
        miso_q.push_back(frame_tx);
        if (withhold) window_frames++;
        next_word = random_bits(spi_pkg::DATA_WIDTH);
      end
      if (cs) check_value("sclk", 32'(sclk), 32'd0);  // cpol=0 idle level
      if (cmd_credit) begin
        cmd_cred++;
        cmd_returned++;
        if (cmd_cred > spi_pkg::CMD_DEPTH) report_failure("command credits above queue depth");
      end
      if (rsp_valid) begin
        if (rsp_avail == 0) report_failure("response sent with no credit left");
        rsp_avail--;
        if (miso_q.size() == 0) begin
          report_failure("response with no finished frame behind it");
        end else begin
          check_value("rsp", rsp.data, miso_q.pop_front());
        end
        rsp_count++;
        owed++;
      end

      // back-pressure window with no credits going back
      if (!withhold && !window_done && rsp_count >= WINDOW_AT) begin
        withhold    = 1'b1;
        window_left = WINDOW_LEN;
      end else if (withhold) begin
        window_left--;
        if (window_left == 0) begin
          withhold    = 1'b0;
          window_done = 1'b1;
          if (window_frames > 2 * spi_pkg::RSP_DEPTH) begin
            report_failure($sformatf("%0d frames finished while credits were held",
                                     window_frames));
          end
        end
      end

      cmd_valid  = 1'b0;
      rsp_credit = 1'b0;
      if (!withhold && owed > 0) begin
        if (credit_wait == 0) begin
          rsp_credit  = 1'b1;
          owed--;
          rsp_avail++;
          credit_wait = int'(random_bits(3));
        end else begin
          credit_wait--;
        end
      end
      if (sent < NUM_WORDS && cmd_cred > 0) begin
        if (gap == 0) begin
          cmd_valid = 1'b1;
          cmd.data  = random_bits(spi_pkg::DATA_WIDTH);
          cmd_q.push_back(cmd.data);
          cmd_cred--;
          sent++;
          gap = int'(random_bits(2));
        end else begin
          gap--;
        end
      end
    end

    // host goes quiet for the tail
    cmd_valid  = 1'b0;
    rsp_credit = 1'b0;

    if (rsp_count < NUM_WORDS) begin
      report_failure($sformatf("timeout after %0d cycles with %0d of %0d responses",
                               cycle, rsp_count, NUM_WORDS));
    end
    repeat (300) begin  // nothing more may show up
      @(negedge clk);
      if (rsp_valid) report_failure("response beyond the last command");
    end
    check_value("responses", 32'(rsp_count), 32'(NUM_WORDS));
    check_value("frames", 32'(frame_cnt), 32'(NUM_WORDS));
    check_value("cmd_credit pulses", 32'(cmd_returned), 32'(NUM_WORDS));
    if (!window_done) report_failure("back-pressure window never ran");
    $display("closing tally: %0d value errors, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
